//--- hdl/riscv_isa_pkg.sv
package riscv_isa_pkg;

    // Major opcodes handled by the core
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;

    // ALU funct3 codes, shared by OP and OP-IMM
    localparam logic [2:0] funct3_add  = 3'b000;
    localparam logic [2:0] funct3_sll  = 3'b001;
    localparam logic [2:0] funct3_slt  = 3'b010;
    localparam logic [2:0] funct3_sltu = 3'b011;
    localparam logic [2:0] funct3_xor  = 3'b100;
    localparam logic [2:0] funct3_sr   = 3'b101;
    localparam logic [2:0] funct3_or   = 3'b110;
    localparam logic [2:0] funct3_and  = 3'b111;

    // Selects SUB and SRA
    localparam logic [6:0] funct7_alt = 7'b0100000;

    // R-type view
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    // I-type view
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // One instruction word, two decodings
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } instr_t;

endpackage

//--- hdl/core_ctrl_pkg.sv
package core_ctrl_pkg;

    // ALU operation, decoded in ID and carried into EX
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_t;

    // Operand source
    typedef enum logic [1:0] {
        FWD_RF  = 2'd0,
        FWD_EX  = 2'd1,
        FWD_MEM = 2'd2
    } fwd_sel_t;

endpackage

//--- hdl/id_stage.sv
`timescale 1ns/100ps

module id_stage (
    input  riscv_isa_pkg::instr_t  ir,
    input  logic                   ir_valid,
    output logic [4:0]             rs1,
    output logic [4:0]             rs2,
    output logic [4:0]             rd,
    output logic [31:0]            imm,
    output core_ctrl_pkg::alu_op_t alu_op,
    output logic                   use_imm,
    output logic                   wr_n
);

    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] imm12;
    logic        is_op;
    logic        is_op_imm;
    logic        alt_r;

    assign opcode = ir.r.opcode;
    assign funct3 = ir.r.funct3;
    assign funct7 = ir.r.funct7;
    assign imm12  = ir.i.imm12;

    assign rs1 = ir.r.rs1;
    assign rs2 = ir.r.rs2;
    assign rd  = ir.r.rd;

    assign is_op     = (opcode == opcode_op);
    assign is_op_imm = (opcode == opcode_op_imm);

    // Bit 30 of the word selects SUB, SRA and SRAI
    assign alt_r = |(funct7 & funct7_alt);

    assign imm     = {{20{imm12[11]}}, imm12};
    assign use_imm = is_op_imm;

    // Bubble, unsupported opcode or x0 target
    assign wr_n = !(ir_valid && (is_op || is_op_imm) && (rd != 5'd0));

    always_comb begin
        case (funct3)
            funct3_add:  alu_op = (is_op && alt_r) ? ALU_SUB : ALU_ADD;
            funct3_sll:  alu_op = ALU_SLL;
            funct3_slt:  alu_op = ALU_SLT;
            funct3_sltu: alu_op = ALU_SLTU;
            funct3_xor:  alu_op = ALU_XOR;
            funct3_sr: begin
                if (alt_r) begin
                    alu_op = ALU_SRA;
                end else begin
                    alu_op = ALU_SRL;
                end
            end
            funct3_or:   alu_op = ALU_OR;
            funct3_and:  alu_op = ALU_AND;
            default:     alu_op = ALU_ADD;
        endcase
    end

endmodule

//--- hdl/rf32x32.sv
`timescale 1ns/100ps

module rf32x32 (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wr_n,
    input  logic [4:0]  wr_addr,
    input  logic [31:0] data_in,
    input  logic [4:0]  rd1_addr,
    input  logic [4:0]  rd2_addr,
    output logic [31:0] data1,
    output logic [31:0] data2
);

    // x0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (!wr_n && (wr_addr != 5'd0)) begin
            regs[wr_addr] <= data_in;
        end
    end

    function automatic logic [31:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end else if (!wr_n && (addr == wr_addr)) begin
            // Write-through from WB
            return data_in;
        end else begin
            return regs[addr];
        end
    endfunction

    always_comb begin
        data1 = read_port(rd1_addr);
        data2 = read_port(rd2_addr);
    end

endmodule

//--- hdl/data_forward_u.sv
`timescale 1ns/100ps

module data_forward_u (
    input  logic [4:0]              rs1,
    input  logic [4:0]              rs2,
    input  logic [4:0]              ex_rd,
    input  logic                    ex_wr_n,
    input  logic [4:0]              mem_rd,
    input  logic                    mem_wr_n,
    output core_ctrl_pkg::fwd_sel_t fwd1,
    output core_ctrl_pkg::fwd_sel_t fwd2
);

    import core_ctrl_pkg::*;

    // Nearer producer wins
    function automatic fwd_sel_t pick(input logic [4:0] rs);
        if (!ex_wr_n && (ex_rd == rs)) begin
            return FWD_EX;
        end else if (!mem_wr_n && (mem_rd == rs)) begin
            return FWD_MEM;
        end else begin
            return FWD_RF;
        end
    endfunction

    always_comb begin
        fwd1 = pick(rs1);
        fwd2 = pick(rs2);
    end

endmodule

//--- hdl/ex_stage.sv
`timescale 1ns/100ps

module ex_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [31:0]             data1,
    input  logic [31:0]             data2,
    input  logic [31:0]             imm,
    input  core_ctrl_pkg::alu_op_t  alu_op,
    input  logic                    use_imm,
    input  logic [4:0]              rd,
    input  logic                    wr_n,
    input  core_ctrl_pkg::fwd_sel_t fwd1,
    input  core_ctrl_pkg::fwd_sel_t fwd2,
    output logic [4:0]              ex_rd,
    output logic                    ex_wr_n,
    output logic [4:0]              mem_rd,
    output logic                    mem_wr_n,
    output logic [31:0]             mem_result,
    output logic                    wb_wr_n,
    output logic [4:0]              wb_rd,
    output logic [31:0]             wb_data
);

    import core_ctrl_pkg::*;

    logic [31:0] data1_q;
    logic [31:0] data2_q;
    logic [31:0] imm_q;
    alu_op_t     alu_op_q;
    logic        use_imm_q;
    fwd_sel_t    fwd1_q;
    fwd_sel_t    fwd2_q;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] ex_result;

    // Pipeline control
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_wr_n  <= 1'b1;
            fwd1_q   <= FWD_RF;
            fwd2_q   <= FWD_RF;
            mem_wr_n <= 1'b1;
            wb_wr_n  <= 1'b1;
        end else begin
            ex_wr_n  <= wr_n;
            fwd1_q   <= fwd1;
            fwd2_q   <= fwd2;
            mem_wr_n <= ex_wr_n;
            wb_wr_n  <= mem_wr_n;
        end
    end

    // Pipeline payload
    always_ff @(posedge clk) begin
        data1_q    <= data1;
        data2_q    <= data2;
        imm_q      <= imm;
        alu_op_q   <= alu_op;
        use_imm_q  <= use_imm;
        ex_rd      <= rd;
        mem_rd     <= ex_rd;
        mem_result <= ex_result;
        wb_rd      <= mem_rd;
        wb_data    <= mem_result;
    end

    function automatic logic [31:0] fwd_pick(input fwd_sel_t sel, input logic [31:0] rf_val);
        case (sel)
            FWD_EX:  return mem_result;
            FWD_MEM: return wb_data;
            default: return rf_val;
        endcase
    endfunction

    always_comb begin
        op_a = fwd_pick(fwd1_q, data1_q);
        op_b = use_imm_q ? imm_q : fwd_pick(fwd2_q, data2_q);
    end

    always_comb begin
        case (alu_op_q)
            ALU_SUB:  ex_result = op_a - op_b;
            ALU_SLL:  ex_result = op_a << op_b[4:0];
            ALU_SLT:  ex_result = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: ex_result = {31'd0, op_a < op_b};
            ALU_XOR:  ex_result = op_a ^ op_b;
            ALU_SRL:  ex_result = op_a >> op_b[4:0];
            ALU_SRA:  ex_result = $unsigned($signed(op_a) >>> op_b[4:0]);
            ALU_OR:   ex_result = op_a | op_b;
            ALU_AND:  ex_result = op_a & op_b;
            default:  ex_result = op_a + op_b;
        endcase
    end

endmodule

//--- hdl/core_top.sv
`timescale 1ns/100ps

module core_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ir_valid,
    input  riscv_isa_pkg::instr_t ir,
    output logic                  wb_wr_n,
    output logic [4:0]            wb_rd,
    output logic [31:0]           wb_data
);

    import core_ctrl_pkg::*;

    // ID
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
    alu_op_t     alu_op;
    logic        use_imm;
    logic        wr_n;

    // Register file
    logic [31:0] data1;
    logic [31:0] data2;

    // Forwarding
    fwd_sel_t    fwd1;
    fwd_sel_t    fwd2;
    logic [4:0]  ex_rd;
    logic        ex_wr_n;
    logic [4:0]  mem_rd;
    logic        mem_wr_n;

    id_stage id_stage_inst (
        .ir(ir),
        .ir_valid(ir_valid),
        .rs1(rs1),
        .rs2(rs2),
        .rd(rd),
        .imm(imm),
        .alu_op(alu_op),
        .use_imm(use_imm),
        .wr_n(wr_n)
    );

    rf32x32 regfile_inst (
        .clk(clk),
        .rst_n(rst_n),
        .wr_n(wb_wr_n),
        .wr_addr(wb_rd),
        .data_in(wb_data),
        .rd1_addr(rs1),
        .rd2_addr(rs2),
        .data1(data1),
        .data2(data2)
    );

    data_forward_u data_forward_u_inst (
        .rs1(rs1),
        .rs2(rs2),
        .ex_rd(ex_rd),
        .ex_wr_n(ex_wr_n),
        .mem_rd(mem_rd),
        .mem_wr_n(mem_wr_n),
        .fwd1(fwd1),
        .fwd2(fwd2)
    );

    ex_stage ex_stage_inst (
        .clk(clk),
        .rst_n(rst_n),
        .data1(data1),
        .data2(data2),
        .imm(imm),
        .alu_op(alu_op),
        .use_imm(use_imm),
        .rd(rd),
        .wr_n(wr_n),
        .fwd1(fwd1),
        .fwd2(fwd2),
        .ex_rd(ex_rd),
        .ex_wr_n(ex_wr_n),
        .mem_rd(mem_rd),
        .mem_wr_n(mem_wr_n),
        .mem_result(),
        .wb_wr_n(wb_wr_n),
        .wb_rd(wb_rd),
        .wb_data(wb_data)
    );

endmodule

//--- test/core_assertions.sv
`timescale 1ns/100ps

module core_assertions (
    input logic       clk,
    input logic       rst_n,
    input logic       ir_valid,
    input logic       wr_n,
    input logic       wb_wr_n,
    input logic [4:0] wb_rd
);

    // Write port stays quiet for two cycles after reset release
    assert property (@(posedge clk) rst_n && ($past(!rst_n) || $past(!rst_n, 2)) |-> wb_wr_n)
        else $error("write-back active right after reset release");

    // Captured at E0, wb outputs change at E2 and are sampled at E3
    assert property (@(posedge clk) disable iff (!rst_n)
        $past(ir_valid && !wr_n, 3) |-> !wb_wr_n)
        else $error("accepted instruction did not reach write-back on time");

    assert property (@(posedge clk) disable iff (!rst_n)
        !wb_wr_n |-> $past(ir_valid, 3))
        else $error("write-back without an instruction in the matching slot");

    assert property (@(posedge clk) disable iff (!rst_n) !wb_wr_n |-> (wb_rd != 5'd0))
        else $error("write-back targets x0");

endmodule

bind core_top core_assertions core_checks (
    .clk(clk),
    .rst_n(rst_n),
    .ir_valid(ir_valid),
    .wr_n(wr_n),
    .wb_wr_n(wb_wr_n),
    .wb_rd(wb_rd)
);

//--- test/tb_core_top.sv
`timescale 1ns/100ps

module tb_core_top;

    import riscv_isa_pkg::*;

    localparam int GAP_RND = -1;

    typedef struct {
        instr_t      ir;
        int          gap;
        bit          we;
        logic [4:0]  rd;
        logic [31:0] data;
    } stim_t;

    typedef struct {
        logic [4:0]  rd;
        logic [31:0] data;
        int          cycle;
    } expect_t;

    logic        clk;
    logic        rst_n;
    logic        ir_valid;
    instr_t      ir;
    logic        wb_wr_n;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    stim_t   stim_q[$];
    expect_t expect_q[$];
    int      errors = 0;
    int      cycle = 0;
    integer  seed;
    bit      table_ready = 1'b0;

    core_top uut (
        .clk(clk),
        .rst_n(rst_n),
        .ir_valid(ir_valid),
        .ir(ir),
        .wb_wr_n(wb_wr_n),
        .wb_rd(wb_rd),
        .wb_data(wb_data)
    );

    function automatic instr_t op_word(input logic [6:0] funct7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] funct3,
                                       input logic [4:0] rd);
        instr_t w;
        w.r.funct7 = funct7;
        w.r.rs2    = rs2;
        w.r.rs1    = rs1;
        w.r.funct3 = funct3;
        w.r.rd     = rd;
        w.r.opcode = opcode_op;
        return w;
    endfunction

    function automatic instr_t imm_word(input logic [11:0] imm12, input logic [4:0] rs1,
                                        input logic [2:0] funct3, input logic [4:0] rd);
        instr_t w;
        w.i.imm12  = imm12;
        w.i.rs1    = rs1;
        w.i.funct3 = funct3;
        w.i.rd     = rd;
        w.i.opcode = opcode_op_imm;
        return w;
    endfunction

    task automatic add_stim(input instr_t w, input int gap, input bit we,
                            input logic [4:0] rd, input logic [31:0] data);
        stim_t s;
        s.ir   = w;
        s.gap  = gap;
        s.we   = we;
        s.rd   = rd;
        s.data = data;
        stim_q.push_back(s);
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t: %s, got 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic fill_table();
        // x1 = 100, x2 = -7, x3 has 4 in its low five bits
        add_stim(imm_word(12'd100, 5'd0, funct3_add, 5'd1), 0, 1'b1, 5'd1, 32'h0000_0064);
        add_stim(imm_word(12'hff9, 5'd0, funct3_add, 5'd2), 0, 1'b1, 5'd2, 32'hffff_fff9);
        add_stim(imm_word(12'h7e4, 5'd0, funct3_add, 5'd3), 3, 1'b1, 5'd3, 32'h0000_07e4);
        add_stim(op_word(7'd0, 5'd2, 5'd1, funct3_add, 5'd4), 1, 1'b1, 5'd4, 32'h0000_005d);
        add_stim(op_word(funct7_alt, 5'd2, 5'd1, funct3_add, 5'd5), 1, 1'b1, 5'd5, 32'h6b);
        add_stim(op_word(7'd0, 5'd1, 5'd2, funct3_slt, 5'd6), 1, 1'b1, 5'd6, 32'h1);
        add_stim(op_word(7'd0, 5'd1, 5'd2, funct3_sltu, 5'd7), 1, 1'b1, 5'd7, 32'h0);
        add_stim(op_word(7'd0, 5'd2, 5'd1, funct3_xor, 5'd8), 1, 1'b1, 5'd8, 32'hffff_ff9d);
        add_stim(op_word(7'd0, 5'd2, 5'd1, funct3_or, 5'd9), 1, 1'b1, 5'd9, 32'hffff_fffd);
        add_stim(op_word(7'd0, 5'd2, 5'd1, funct3_and, 5'd10), 1, 1'b1, 5'd10, 32'h60);
        add_stim(op_word(7'd0, 5'd3, 5'd1, funct3_sll, 5'd11), 1, 1'b1, 5'd11, 32'h640);
        add_stim(op_word(7'd0, 5'd3, 5'd2, funct3_sr, 5'd12), 1, 1'b1, 5'd12, 32'h0fff_ffff);
        add_stim(op_word(funct7_alt, 5'd3, 5'd2, funct3_sr, 5'd13), 1, 1'b1, 5'd13, '1);
        add_stim(imm_word(12'hffa, 5'd2, funct3_slt, 5'd14), 1, 1'b1, 5'd14, 32'h1);
        add_stim(imm_word(12'hfff, 5'd1, funct3_sltu, 5'd15), 1, 1'b1, 5'd15, 32'h1);
        add_stim(imm_word(12'hfff, 5'd1, funct3_xor, 5'd16), 1, 1'b1, 5'd16, 32'hffff_ff9b);
        add_stim(imm_word(12'h0f0, 5'd1, funct3_or, 5'd17), 1, 1'b1, 5'd17, 32'hf4);
        add_stim(imm_word(12'h0f0, 5'd2, funct3_and, 5'd18), 1, 1'b1, 5'd18, 32'hf0);
        add_stim(imm_word(12'h008, 5'd1, funct3_sll, 5'd19), 1, 1'b1, 5'd19, 32'h6400);
        add_stim(imm_word(12'h01c, 5'd2, funct3_sr, 5'd20), 1, 1'b1, 5'd20, 32'hf);
        add_stim(imm_word(12'h401, 5'd2, funct3_sr, 5'd21), 0, 1'b1, 5'd21, 32'hffff_fffc);
        // Back to back with operands from EX, MEM and the bypass
        add_stim(imm_word(12'd5, 5'd0, funct3_add, 5'd23), 0, 1'b1, 5'd23, 32'h5);
        add_stim(op_word(7'd0, 5'd23, 5'd23, funct3_add, 5'd24), 0, 1'b1, 5'd24, 32'ha);
        add_stim(op_word(funct7_alt, 5'd23, 5'd24, funct3_add, 5'd25), 0, 1'b1, 5'd25, 32'h5);
        add_stim(op_word(7'd0, 5'd25, 5'd23, funct3_add, 5'd26), 0, 1'b1, 5'd26, 32'ha);
        add_stim(imm_word(12'd1, 5'd24, funct3_sll, 5'd27), 0, 1'b1, 5'd27, 32'h14);
        // Same target in flight twice
        add_stim(imm_word(12'd1, 5'd0, funct3_add, 5'd28), 0, 1'b1, 5'd28, 32'h1);
        add_stim(imm_word(12'd2, 5'd0, funct3_add, 5'd28), 0, 1'b1, 5'd28, 32'h2);
        add_stim(op_word(7'd0, 5'd0, 5'd28, funct3_add, 5'd29), 0, 1'b1, 5'd29, 32'h2);
        add_stim(imm_word(12'd3, 5'd28, funct3_add, 5'd28), 0, 1'b1, 5'd28, 32'h5);
        // x0 target and then LUI and LW that the core does not execute
        add_stim(imm_word(12'd5, 5'd0, funct3_add, 5'd0), 0, 1'b0, 5'd0, 32'h0);
        add_stim(instr_t'(32'h1234_52b7), 0, 1'b0, 5'd0, 32'h0);
        add_stim(instr_t'(32'h0000_a303), 0, 1'b0, 5'd0, 32'h0);
        add_stim(imm_word(12'h0ff, 5'd0, funct3_xor, 5'd30), 0, 1'b1, 5'd30, 32'hff);
        add_stim(op_word(7'd0, 5'd0, 5'd5, funct3_add, 5'd31), 0, 1'b1, 5'd31, 32'h6b);
        // Dependent chain with random spacing
        add_stim(imm_word(12'h123, 5'd0, funct3_add, 5'd1), GAP_RND, 1'b1, 5'd1, 32'h123);
        add_stim(op_word(7'd0, 5'd24, 5'd1, funct3_xor, 5'd2), GAP_RND, 1'b1, 5'd2, 32'h129);
        add_stim(op_word(funct7_alt, 5'd1, 5'd2, funct3_add, 5'd3), GAP_RND, 1'b1, 5'd3, 32'h6);
        add_stim(op_word(7'd0, 5'd3, 5'd2, funct3_sll, 5'd4), GAP_RND, 1'b1, 5'd4, 32'h4a40);
        add_stim(op_word(7'd0, 5'd4, 5'd3, funct3_sltu, 5'd5), 0, 1'b1, 5'd5, 32'h1);
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Scoreboard sampled away from the active edge
    always @(negedge clk) begin
        expect_t e;
        if (rst_n && !wb_wr_n) begin
            if (expect_q.size() == 0) begin
                errors++;
                $display("Unexpected write-back to x%0d at %0t with nothing pending",
                         wb_rd, $time);
            end else begin
                e = expect_q.pop_front();
                check_value({27'd0, wb_rd}, {27'd0, e.rd}, "write-back register");
                check_value(wb_data, e.data, "write-back data");
                check_value(cycle, e.cycle, "write-back cycle");
            end
        end
    end

    initial begin
        wait (table_ready);
        repeat (stim_q.size() * 8 + 20) @(posedge clk);
        $display("Timeout after %0d cycles with %0d results still pending",
                 stim_q.size() * 8 + 20, expect_q.size());
        $display("Regression failed");
        $finish;
    end

    initial begin
        int      gap;
        expect_t e;
        seed     = 81;
        rst_n    = 1'b0;
        ir_valid = 1'b0;
        ir       = '0;
        fill_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // Idle pipeline must stay silent
        repeat (4) @(posedge clk);
        for (int i = 0; i < stim_q.size(); i++) begin
            @(posedge clk);
            #1;
            ir       = stim_q[i].ir;
            ir_valid = 1'b1;
            if (stim_q[i].we) begin
                // Captured at the next edge and on the write port two edges later
                e.rd    = stim_q[i].rd;
                e.data  = stim_q[i].data;
                e.cycle = cycle + 3;
                expect_q.push_back(e);
            end
            if (stim_q[i].gap == GAP_RND) begin
                gap = $unsigned($random(seed)) % 4;
            end else begin
                gap = stim_q[i].gap;
            end
            repeat (gap) begin
                @(posedge clk);
                #1;
                ir_valid = 1'b0;
                ir       = '0;
            end
        end
        @(posedge clk);
        #1;
        ir_valid = 1'b0;
        ir       = '0;
        while (expect_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- all.f
hdl/riscv_isa_pkg.sv
hdl/core_ctrl_pkg.sv
hdl/id_stage.sv
hdl/rf32x32.sv
hdl/data_forward_u.sv
hdl/ex_stage.sv
hdl/core_top.sv
test/core_assertions.sv
test/tb_core_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module tb_core_top \
    -Mdir obj_dir -o sim_core \
    -f all.f

./obj_dir/sim_core | tee sim.log

if grep -q "Regression failed" sim.log; then
    echo "Simulation reported errors, see sim.log"
    exit 1
fi

echo "Simulation clean"
